// File: source/dcachePkg.sv
`default_nettype none

package dcachePkg;

  // widths with a meaning of their own
  typedef logic [31:0]  addr_t;
  typedef logic [63:0]  word_t;
  typedef logic [7:0]   mask_t;
  typedef logic [20:0]  tag_t;
  typedef logic [5:0]   index_t;
  typedef logic [255:0] line_t;
  typedef logic [1:0]   beat_t;
  typedef logic         way_t;

  // pipeline request, 105 bits
  typedef struct packed {
    logic  wr;
    addr_t addr;
    // store data and byte enables, lane 0 at the addressed byte
    word_t data;
    mask_t mask;
  } cacheReq_t;

  // load data, zero for a store
  typedef struct packed {
    word_t data;
  } cacheRsp_t;

  // controller states
  typedef enum logic [2:0] {
    idle,
    compare,
    miss,
    wrBack,
    getData,
    replace
  } ctrlState_t;

endpackage

`default_nettype wire

// File: source/refillBuffer.sv
`timescale 1ns/1ps
`default_nettype none

module refillBuffer (
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire                   memDataValid_i,
  input  wire dcachePkg::word_t memData_i,
  input  wire                   memLast_i,
  output dcachePkg::line_t      line_o,
  output logic                  beatsDone_o
);

  dcachePkg::beat_t beatCnt;
  dcachePkg::line_t lineQ;

  assign line_o = lineQ;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beatCnt     <= '0;
      beatsDone_o <= 1'b0;
    end else begin
      beatsDone_o <= memDataValid_i && memLast_i;
      if (memDataValid_i) begin
        // ready for the next burst after the last beat
        beatCnt <= memLast_i ? '0 : beatCnt + 2'd1;
      end
    end
  end

  // beats arrive lowest word first
  always_ff @(posedge clk) begin
    if (memDataValid_i) begin
      lineQ[{beatCnt, 6'd0} +: 64] <= memData_i;
    end
  end

endmodule

`default_nettype wire

// File: source/tagStore.sv
`timescale 1ns/1ps
`default_nettype none

module tagStore (
  input  wire                    clk,
  input  wire                    rst_n,
  input  wire dcachePkg::index_t lookIndex_i,
  input  wire dcachePkg::tag_t   lookTag_i,
  output logic                   hit_o,
  output dcachePkg::way_t        hitWay_o,
  output dcachePkg::way_t        victimWay_o,
  output logic                   victimDirty_o,
  output dcachePkg::tag_t        victimTag_o,
  input  wire                    setDirty_i,
  input  wire dcachePkg::way_t   dirtyWay_i,
  input  wire                    fill_i,
  input  wire dcachePkg::way_t   fillWay_i
);

  dcachePkg::tag_t tagMem [2][64];
  logic [1:0][63:0] validBits;
  logic [1:0][63:0] dirtyBits;
  // way to replace next once both ways are valid
  logic [63:0] rrBits;

  logic [1:0] wayHit;
  logic [1:0] wayValid;

  always_comb begin
    for (int w = 0; w < 2; w++) begin
      wayValid[w] = validBits[w][lookIndex_i];
      wayHit[w]   = wayValid[w] && (tagMem[w][lookIndex_i] == lookTag_i);
    end
  end

  assign hit_o    = |wayHit;
  assign hitWay_o = wayHit[1];

  // an empty way is taken before the round-robin choice
  always_comb begin
    if (!wayValid[0]) begin
      victimWay_o = 1'b0;
    end else if (!wayValid[1]) begin
      victimWay_o = 1'b1;
    end else begin
      victimWay_o = rrBits[lookIndex_i];
    end
  end

  assign victimDirty_o = wayValid[victimWay_o] && dirtyBits[victimWay_o][lookIndex_i];
  assign victimTag_o   = tagMem[victimWay_o][lookIndex_i];

  always_ff @(posedge clk) begin
    if (fill_i) begin
      tagMem[fillWay_i][lookIndex_i] <= lookTag_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validBits <= '0;
      dirtyBits <= '0;
      rrBits    <= '0;
    end else if (fill_i) begin
      validBits[fillWay_i][lookIndex_i] <= 1'b1;
      dirtyBits[fillWay_i][lookIndex_i] <= 1'b0;
      rrBits[lookIndex_i]               <= ~rrBits[lookIndex_i];
    end else if (setDirty_i) begin
      dirtyBits[dirtyWay_i][lookIndex_i] <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: source/dataStore.sv
`timescale 1ns/1ps
`default_nettype none

module dataStore (
  input  wire                    clk,
  input  wire dcachePkg::index_t index_i,
  input  wire dcachePkg::way_t   rdWay_i,
  output dcachePkg::line_t       lineRd_o,
  input  wire dcachePkg::way_t   victimWay_i,
  output dcachePkg::line_t       victimLine_o,
  input  wire                    wrEn_i,
  input  wire dcachePkg::way_t   wrWay_i,
  input  wire dcachePkg::beat_t  wrWord_i,
  input  wire dcachePkg::word_t  wrData_i,
  input  wire dcachePkg::mask_t  wrMask_i,
  input  wire                    fill_i,
  input  wire dcachePkg::way_t   fillWay_i,
  input  wire dcachePkg::line_t  fillLine_i
);

  // one line array per way
  dcachePkg::line_t lineMem [2][64];

  logic [7:0] wordBase;

  assign wordBase = {wrWord_i, 6'd0};

  // both read ports are combinational
  assign lineRd_o     = lineMem[rdWay_i][index_i];
  assign victimLine_o = lineMem[victimWay_i][index_i];

  always_ff @(posedge clk) begin
    if (fill_i) begin
      lineMem[fillWay_i][index_i] <= fillLine_i;
    end else if (wrEn_i) begin
      // only enabled bytes of the word change
      for (int b = 0; b < 8; b++) begin
        if (wrMask_i[b]) begin
          lineMem[wrWay_i][index_i][int'(wordBase) + b * 8 +: 8] <= wrData_i[b * 8 +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: source/dcacheCtrl.sv
`timescale 1ns/1ps
`default_nettype none

module dcacheCtrl (
  input  wire                      clk,
  input  wire                      rst_n,
  input  wire                      reqValid_i,
  input  wire dcachePkg::cacheReq_t req_i,
  output logic                     reqReady_o,
  output logic                     rspValid_o,
  output dcachePkg::cacheRsp_t     rsp_o,
  output logic                     memRdValid_o,
  input  wire                      memRdReady_i,
  output dcachePkg::addr_t         memRdAddr_o,
  output logic                     memWrValid_o,
  input  wire                      memWrReady_i,
  output dcachePkg::addr_t         memWrAddr_o,
  output dcachePkg::line_t         memWrData_o,
  output dcachePkg::index_t        lookIndex_o,
  output dcachePkg::tag_t          lookTag_o,
  input  wire                      hit_i,
  input  wire dcachePkg::way_t     hitWay_i,
  input  wire dcachePkg::way_t     victimWay_i,
  input  wire                      victimDirty_i,
  input  wire dcachePkg::tag_t     victimTag_i,
  output logic                     setDirty_o,
  output logic                     fill_o,
  output dcachePkg::way_t          fillWay_o,
  output logic                     wrEn_o,
  output dcachePkg::way_t          wrWay_o,
  output dcachePkg::beat_t         wrWord_o,
  output dcachePkg::word_t         wrData_o,
  output dcachePkg::mask_t         wrMask_o,
  input  wire dcachePkg::line_t    lineRd_i,
  input  wire dcachePkg::line_t    victimLine_i,
  input  wire                      beatsDone_i
);

  dcachePkg::ctrlState_t state;
  dcachePkg::ctrlState_t stateNext;
  dcachePkg::cacheReq_t  reqQ;

  // latched address fields
  dcachePkg::index_t index;
  dcachePkg::tag_t   tag;
  dcachePkg::beat_t  word;
  logic [2:0]        byteOff;
  logic              cmpHit;

  assign index   = reqQ.addr[10:5];
  assign tag     = reqQ.addr[31:11];
  assign word    = reqQ.addr[4:3];
  assign byteOff = reqQ.addr[2:0];
  assign cmpHit  = (state == dcachePkg::compare) && hit_i;

  assign lookIndex_o = index;
  assign lookTag_o   = tag;

  // a hit frees the latch for the next request in the same cycle
  assign reqReady_o = (state == dcachePkg::idle) || cmpHit;

  always_ff @(posedge clk) begin
    if (reqValid_i && reqReady_o) begin
      reqQ <= req_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= dcachePkg::idle;
    end else begin
      state <= stateNext;
    end
  end

  always_comb begin
    stateNext = state;
    case (state)
      dcachePkg::idle: begin
        if (reqValid_i) begin
          stateNext = dcachePkg::compare;
        end
      end
      dcachePkg::compare: begin
        if (!hit_i) begin
          stateNext = victimDirty_i ? dcachePkg::wrBack : dcachePkg::miss;
        end else if (!reqValid_i) begin
          stateNext = dcachePkg::idle;
        end
      end
      // victim goes out before the refill is asked for
      dcachePkg::wrBack: begin
        if (memWrReady_i) begin
          stateNext = dcachePkg::miss;
        end
      end
      dcachePkg::miss: begin
        if (memRdReady_i) begin
          stateNext = dcachePkg::getData;
        end
      end
      dcachePkg::getData: begin
        if (beatsDone_i) begin
          stateNext = dcachePkg::replace;
        end
      end
      // line is in place, retry the request as a hit
      dcachePkg::replace: begin
        stateNext = dcachePkg::compare;
      end
      default: begin
        stateNext = dcachePkg::idle;
      end
    endcase
  end

  assign rspValid_o = cmpHit;
  assign rsp_o.data = reqQ.wr ? '0 : lineRd_i[{word, 6'd0} +: 64];

  // store hit, data and mask moved to the addressed byte lane
  assign wrEn_o     = cmpHit && reqQ.wr;
  assign setDirty_o = cmpHit && reqQ.wr;
  assign wrWay_o    = hitWay_i;
  assign wrWord_o   = word;
  assign wrData_o   = reqQ.data << {byteOff, 3'b000};
  assign wrMask_o   = reqQ.mask << byteOff;

  assign fill_o    = (state == dcachePkg::replace);
  assign fillWay_o = victimWay_i;

  assign memRdValid_o = (state == dcachePkg::miss);
  assign memRdAddr_o  = {tag, index, 5'd0};

  assign memWrValid_o = (state == dcachePkg::wrBack);
  assign memWrAddr_o  = {victimTag_i, index, 5'd0};
  assign memWrData_o  = victimLine_i;

endmodule

`default_nettype wire

// File: source/dcacheTop.sv
`timescale 1ns/1ps
`default_nettype none

module dcacheTop (
  input  wire                    clk,
  input  wire                    rst_n,
  input  wire                    reqValid_i,
  input  wire dcachePkg::cacheReq_t req_i,
  output logic                   reqReady_o,
  output logic                   rspValid_o,
  output dcachePkg::cacheRsp_t   rsp_o,
  output logic                   memRdValid_o,
  input  wire                    memRdReady_i,
  output dcachePkg::addr_t       memRdAddr_o,
  input  wire                    memDataValid_i,
  input  wire dcachePkg::word_t  memData_i,
  input  wire                    memLast_i,
  output logic                   memWrValid_o,
  input  wire                    memWrReady_i,
  output dcachePkg::addr_t       memWrAddr_o,
  output dcachePkg::line_t       memWrData_o
);

  dcachePkg::index_t lookIndex;
  dcachePkg::tag_t   lookTag;
  logic              hit;
  dcachePkg::way_t   hitWay;
  dcachePkg::way_t   victimWay;
  logic              victimDirty;
  dcachePkg::tag_t   victimTag;
  logic              setDirty;
  logic              fill;
  dcachePkg::way_t   fillWay;
  logic              wrEn;
  dcachePkg::way_t   wrWay;
  dcachePkg::beat_t  wrWord;
  dcachePkg::word_t  wrData;
  dcachePkg::mask_t  wrMask;
  dcachePkg::line_t  lineRd;
  dcachePkg::line_t  victimLine;
  dcachePkg::line_t  refillLine;
  logic              beatsDone;

  dcacheCtrl u_dcacheCtrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .reqValid_i    (reqValid_i),
    .req_i         (req_i),
    .reqReady_o    (reqReady_o),
    .rspValid_o    (rspValid_o),
    .rsp_o         (rsp_o),
    .memRdValid_o  (memRdValid_o),
    .memRdReady_i  (memRdReady_i),
    .memRdAddr_o   (memRdAddr_o),
    .memWrValid_o  (memWrValid_o),
    .memWrReady_i  (memWrReady_i),
    .memWrAddr_o   (memWrAddr_o),
    .memWrData_o   (memWrData_o),
    .lookIndex_o   (lookIndex),
    .lookTag_o     (lookTag),
    .hit_i         (hit),
    .hitWay_i      (hitWay),
    .victimWay_i   (victimWay),
    .victimDirty_i (victimDirty),
    .victimTag_i   (victimTag),
    .setDirty_o    (setDirty),
    .fill_o        (fill),
    .fillWay_o     (fillWay),
    .wrEn_o        (wrEn),
    .wrWay_o       (wrWay),
    .wrWord_o      (wrWord),
    .wrData_o      (wrData),
    .wrMask_o      (wrMask),
    .lineRd_i      (lineRd),
    .victimLine_i  (victimLine),
    .beatsDone_i   (beatsDone)
  );

  // store hits mark the way they wrote as dirty
  tagStore u_tagStore (
    .clk           (clk),
    .rst_n         (rst_n),
    .lookIndex_i   (lookIndex),
    .lookTag_i     (lookTag),
    .hit_o         (hit),
    .hitWay_o      (hitWay),
    .victimWay_o   (victimWay),
    .victimDirty_o (victimDirty),
    .victimTag_o   (victimTag),
    .setDirty_i    (setDirty),
    .dirtyWay_i    (wrWay),
    .fill_i        (fill),
    .fillWay_i     (fillWay)
  );

  dataStore u_dataStore (
    .clk          (clk),
    .index_i      (lookIndex),
    .rdWay_i      (hitWay),
    .lineRd_o     (lineRd),
    .victimWay_i  (victimWay),
    .victimLine_o (victimLine),
    .wrEn_i       (wrEn),
    .wrWay_i      (wrWay),
    .wrWord_i     (wrWord),
    .wrData_i     (wrData),
    .wrMask_i     (wrMask),
    .fill_i       (fill),
    .fillWay_i    (fillWay),
    .fillLine_i   (refillLine)
  );

  refillBuffer u_refillBuffer (
    .clk            (clk),
    .rst_n          (rst_n),
    .memDataValid_i (memDataValid_i),
    .memData_i      (memData_i),
    .memLast_i      (memLast_i),
    .line_o         (refillLine),
    .beatsDone_o    (beatsDone)
  );

endmodule

`default_nettype wire

// File: tests/clockGen.sv
`timescale 1ns/1ps
`default_nettype none

module clockGen (
  output logic clk_o,
  output logic rst_n_o
);

  // 100 ns period
  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;
  end

  // reset held low over the first 16 rising edges
  initial begin
    rst_n_o = 1'b0;
    repeat (16) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

`default_nettype wire

// File: tests/dcacheTb.sv
`timescale 1ns/1ps
`default_nettype none

module dcacheTb;

  // about 20 cycles per miss at worst back-pressure over roughly 215 requests
  localparam int timeoutCycles = 20000;

  logic clk;
  logic rst_n;

  logic                 reqValid;
  dcachePkg::cacheReq_t req;
  logic                 reqReady;
  logic                 rspValid;
  dcachePkg::cacheRsp_t rsp;
  logic                 memRdValid;
  logic                 memRdReady = 1'b0;
  dcachePkg::addr_t     memRdAddr;
  logic                 memDataValid = 1'b0;
  dcachePkg::word_t     memData = '0;
  logic                 memLast = 1'b0;
  logic                 memWrValid;
  logic                 memWrReady = 1'b0;
  dcachePkg::addr_t     memWrAddr;
  dcachePkg::line_t     memWrData;

  // expected view of memory as the pipeline sees it
  dcachePkg::word_t shadow [dcachePkg::addr_t];
  // what the memory itself holds, changed only by writebacks
  dcachePkg::word_t memImage [dcachePkg::addr_t];

  int checkCount = 0;
  int cycleCount = 0;
  int rdCount = 0;
  int wbCount = 0;
  int rdWait = 0;
  int wrWait = 0;
  int beatIdx = 0;
  logic burstActive = 1'b0;
  dcachePkg::addr_t burstAddr = '0;
  dcachePkg::addr_t lastRdAddr = '0;
  dcachePkg::addr_t lastWbAddr = '0;
  dcachePkg::line_t lastWbLine = '0;
  dcachePkg::line_t expLine;

  // memory-side outputs captured half a cycle before the edge
  logic             rdValidS = 1'b0;
  dcachePkg::addr_t rdAddrS = '0;
  logic             wrValidS = 1'b0;
  dcachePkg::addr_t wrAddrS = '0;
  dcachePkg::line_t wrDataS = '0;

  clockGen u_clockGen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  dcacheTop u_dcacheTop (
    .clk            (clk),
    .rst_n          (rst_n),
    .reqValid_i     (reqValid),
    .req_i          (req),
    .reqReady_o     (reqReady),
    .rspValid_o     (rspValid),
    .rsp_o          (rsp),
    .memRdValid_o   (memRdValid),
    .memRdReady_i   (memRdReady),
    .memRdAddr_o    (memRdAddr),
    .memDataValid_i (memDataValid),
    .memData_i      (memData),
    .memLast_i      (memLast),
    .memWrValid_o   (memWrValid),
    .memWrReady_i   (memWrReady),
    .memWrAddr_o    (memWrAddr),
    .memWrData_o    (memWrData)
  );

  task automatic reportError(input string msg);
    $display("[ERROR] %0t ns: %s", $time, msg);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic compareWord(input string what, input dcachePkg::word_t got,
                             input dcachePkg::word_t exp);
    checkCount++;
    assert (got === exp) else
      reportError($sformatf("%s: got %h, expected %h", what, got, exp));
  endtask

  task automatic requireTrue(input string what, input logic cond);
    checkCount++;
    assert (cond === 1'b1) else reportError(what);
  endtask

  // untouched words hold their own address twice
  function automatic dcachePkg::word_t expectedWord(input dcachePkg::addr_t addr);
    if (shadow.exists(addr)) begin
      return shadow[addr];
    end
    return {addr, addr};
  endfunction

  function automatic dcachePkg::word_t backingWord(input dcachePkg::addr_t addr);
    if (memImage.exists(addr)) begin
      return memImage[addr];
    end
    return {addr, addr};
  endfunction

  function automatic dcachePkg::line_t latestLine(input dcachePkg::addr_t base);
    dcachePkg::line_t line;
    for (int w = 0; w < 4; w++) begin
      line[w * 64 +: 64] = expectedWord(base + w * 8);
    end
    return line;
  endfunction

  function automatic void mergeStore(input dcachePkg::addr_t addr, input dcachePkg::word_t data,
                                     input dcachePkg::mask_t mask);
    dcachePkg::word_t w;
    w = expectedWord(addr);
    for (int b = 0; b < 8; b++) begin
      if (mask[b]) begin
        w[b * 8 +: 8] = data[b * 8 +: 8];
      end
    end
    shadow[addr] = w;
  endfunction

  always @(negedge clk) begin
    rdValidS = memRdValid;
    rdAddrS  = memRdAddr;
    wrValidS = memWrValid;
    wrAddrS  = memWrAddr;
    wrDataS  = memWrData;
  end

  // memory model with a random ready delay and a 4-beat burst per read
  always @(posedge clk) begin
    if (rdValidS && memRdReady) begin
      memRdReady  <= 1'b0;
      rdWait      = $urandom_range(3, 0);
      rdCount++;
      lastRdAddr  = rdAddrS;
      burstAddr   = rdAddrS;
      beatIdx     = 0;
      burstActive = 1'b1;
      memDataValid <= 1'b0;
      memLast      <= 1'b0;
    end else begin
      if (rdValidS) begin
        if (rdWait == 0) begin
          memRdReady <= 1'b1;
        end else begin
          rdWait--;
        end
      end
      if (burstActive) begin
        memDataValid <= 1'b1;
        memData      <= backingWord(burstAddr + beatIdx * 8);
        memLast      <= (beatIdx == 3);
        burstActive  = (beatIdx != 3);
        beatIdx++;
      end else begin
        memDataValid <= 1'b0;
        memLast      <= 1'b0;
      end
    end
    if (wrValidS && memWrReady) begin
      memWrReady <= 1'b0;
      wrWait     = $urandom_range(3, 0);
      requireTrue("writeback address not line aligned", wrAddrS[4:0] == 5'd0);
      // a dirty line carries every store made to it
      expLine = latestLine(wrAddrS);
      checkCount++;
      assert (wrDataS === expLine) else
        reportError($sformatf("writeback of line 0x%08h: got %h, expected %h",
                              wrAddrS, wrDataS, expLine));
      for (int w = 0; w < 4; w++) begin
        memImage[wrAddrS + w * 8] = wrDataS[w * 64 +: 64];
      end
      wbCount++;
      lastWbAddr = wrAddrS;
      lastWbLine = wrDataS;
    end else if (wrValidS) begin
      if (wrWait == 0) begin
        memWrReady <= 1'b1;
      end else begin
        wrWait--;
      end
    end
  end

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= timeoutCycles) begin
      $display("run timed out after %0d cycles", timeoutCycles);
      $display("Checks failed");
      $fatal(1);
    end
  end

  // send one request and wait for its response
  task automatic sendReq(input logic wr, input dcachePkg::addr_t addr,
                         input dcachePkg::word_t data, input dcachePkg::mask_t mask,
                         output dcachePkg::word_t rdData, output int latency);
    logic accepted;
    logic done;
    accepted = 1'b0;
    done     = 1'b0;
    latency  = 0;
    rdData   = '0;
    @(posedge clk);
    reqValid <= 1'b1;
    req      <= '{wr: wr, addr: addr, data: data, mask: mask};
    while (!accepted) begin
      @(negedge clk);
      accepted = reqReady;
      @(posedge clk);
    end
    reqValid <= 1'b0;
    while (!done) begin
      @(negedge clk);
      latency++;
      if (rspValid) begin
        done   = 1'b1;
        rdData = rsp.data;
      end else begin
        requireTrue("reqReady_o high while a miss is pending", reqReady === 1'b0);
      end
    end
  endtask

  task automatic afterResetIdle();
    @(negedge clk);
    requireTrue("reqReady_o low after reset", reqReady);
    requireTrue("rspValid_o high after reset", !rspValid);
    requireTrue("memRdValid_o high after reset", !memRdValid);
    requireTrue("memWrValid_o high after reset", !memWrValid);
  endtask

  task automatic loadMissThenHit();
    dcachePkg::word_t got;
    int lat;
    int rdBefore;
    rdBefore = rdCount;
    sendReq(1'b0, 32'h0000_1048, '0, '0, got, lat);
    requireTrue("miss did not fetch exactly one line", rdCount == rdBefore + 1);
    requireTrue("refill address not the aligned line", lastRdAddr == 32'h0000_1040);
    compareWord("load miss 0x00001048", got, expectedWord(32'h0000_1048));
    sendReq(1'b0, 32'h0000_1048, '0, '0, got, lat);
    requireTrue("hit latency is not one cycle", lat == 1);
    requireTrue("hit went to memory", rdCount == rdBefore + 1);
    compareWord("load hit 0x00001048", got, expectedWord(32'h0000_1048));
  endtask

  task automatic partialStoreMerge();
    dcachePkg::word_t got;
    int lat;
    sendReq(1'b1, 32'h0000_1050, 64'h1122_3344_5566_7788, 8'ha5, got, lat);
    requireTrue("store hit latency is not one cycle", lat == 1);
    compareWord("store response", got, '0);
    mergeStore(32'h0000_1050, 64'h1122_3344_5566_7788, 8'ha5);
    sendReq(1'b0, 32'h0000_1050, '0, '0, got, lat);
    compareWord("load after masked store", got, expectedWord(32'h0000_1050));
  endtask

  // back-to-back loads to a cached line, one accepted behind each hit
  task automatic streamHits();
    dcachePkg::addr_t addrs [4];
    int sent;
    int rcvd;
    logic accepted;
    logic pending;
    sent     = 0;
    rcvd     = 0;
    accepted = 1'b0;
    pending  = 1'b0;
    for (int i = 0; i < 4; i++) begin
      addrs[i] = 32'h0000_1040 + i * 8;
    end
    @(posedge clk);
    reqValid <= 1'b1;
    req      <= '{wr: 1'b0, addr: addrs[0], data: '0, mask: '0};
    while (rcvd < 4) begin
      @(negedge clk);
      requireTrue("streamed hit response not one cycle after acceptance",
                  rspValid === pending);
      if (rspValid) begin
        compareWord($sformatf("streamed load 0x%08h", addrs[rcvd]), rsp.data,
                    expectedWord(addrs[rcvd]));
        rcvd++;
      end
      if (sent > 0 && sent < 4) begin
        requireTrue("reqReady_o low behind a hit", reqReady === 1'b1);
      end
      accepted = reqValid && reqReady;
      @(posedge clk);
      pending = accepted;
      if (accepted) begin
        sent++;
        if (sent < 4) begin
          req <= '{wr: 1'b0, addr: addrs[sent], data: '0, mask: '0};
        end else begin
          reqValid <= 1'b0;
        end
      end
    end
  endtask

  // three tags on index 20 with invalid-first then round-robin victims
  task automatic conflictEviction();
    dcachePkg::addr_t lineA;
    dcachePkg::addr_t lineB;
    dcachePkg::addr_t lineC;
    dcachePkg::word_t got;
    dcachePkg::line_t dirtyLine;
    int lat;
    int wbBefore;
    lineA = {21'h00a11, 6'd20, 5'd0};
    lineB = {21'h00b22, 6'd20, 5'd0};
    lineC = {21'h00c33, 6'd20, 5'd0};
    // one full word stored into an otherwise untouched line
    dirtyLine = {lineA + 32'd24, lineA + 32'd24, lineA + 32'd16, lineA + 32'd16,
                 64'hdead_beef_0bad_f00d, lineA, lineA};
    sendReq(1'b0, lineA, '0, '0, got, lat);
    sendReq(1'b1, lineA + 8, 64'hdead_beef_0bad_f00d, 8'hff, got, lat);
    mergeStore(lineA + 8, 64'hdead_beef_0bad_f00d, 8'hff);
    sendReq(1'b0, lineB, '0, '0, got, lat);
    wbBefore = wbCount;
    sendReq(1'b0, lineC + 16, '0, '0, got, lat);
    compareWord("load of third line", got, expectedWord(lineC + 16));
    requireTrue("dirty victim not written back once", wbCount == wbBefore + 1);
    requireTrue("writeback address is not the dirty line", lastWbAddr == lineA);
    requireTrue("writeback data is not the dirty line", lastWbLine === dirtyLine);
    wbBefore = wbCount;
    sendReq(1'b0, lineA + 8, '0, '0, got, lat);
    compareWord("reload of evicted line", got, expectedWord(lineA + 8));
    requireTrue("clean victim was written back", wbCount == wbBefore);
  endtask

  task automatic mixedTraffic();
    dcachePkg::addr_t addr;
    dcachePkg::word_t data;
    dcachePkg::word_t got;
    dcachePkg::mask_t mask;
    logic wr;
    int lat;
    for (int n = 0; n < 200; n++) begin
      // word-aligned addresses over 6 tags and indexes 40 to 43
      addr = {21'h00100 + 21'($urandom_range(5, 0)), 6'd40 + 6'($urandom_range(3, 0)),
              2'($urandom_range(3, 0)), 3'b000};
      wr   = 1'($urandom_range(1, 0));
      data = {$urandom, $urandom};
      mask = 8'($urandom);
      sendReq(wr, addr, data, mask, got, lat);
      if (wr) begin
        compareWord("store response", got, '0);
        mergeStore(addr, data, mask);
      end else begin
        compareWord($sformatf("load 0x%08h", addr), got, expectedWord(addr));
      end
    end
  endtask

  initial begin
    void'($urandom(32'hf6bc));
    reqValid <= 1'b0;
    req      <= '0;
    wait (rst_n === 1'b1);
    afterResetIdle();
    loadMissThenHit();
    partialStoreMerge();
    streamHits();
    conflictEviction();
    mixedTraffic();
    if (checkCount > 0) begin
      $display("All checks passed");
      $finish;
    end else begin
      $display("no checks were run");
      $display("Checks failed");
      $fatal(1);
    end
  end

endmodule

`default_nettype wire

// File: flist.f
source/dcachePkg.sv
source/refillBuffer.sv
source/tagStore.sv
source/dataStore.sv
source/dcacheCtrl.sv
source/dcacheTop.sv
tests/clockGen.sv
tests/dcacheTb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        ?= dcacheTb
RTL_TOP    ?= dcacheTop
FLIST      ?= flist.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR)
